//--- sources.f
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_writeback.sv
ex_stage.sv
ex_stage_properties.sv
tb_ex_stage.sv

//--- tb_ex_stage.sv
//////////////////////////////////////////////////
// Execute stage testbench
// Random stimulus through the ALU, multiplier,
// CSR, load port and stall paths
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

  // Tests take about 200 cycles and the limit is ten times that
  localparam int max_cycles = 2000;

  logic                      clk, rst_n;
  logic                      alu_en_i, mult_en_i, csr_access_i, lsu_en_i;
  logic                      lsu_ready_ex_i, branch_in_ex_i, wb_ready_i;
  logic                      regfile_alu_we_i, regfile_we_i;
  logic [reg_addr_width-1:0] regfile_alu_waddr_i, regfile_waddr_i;
  logic [xlen-1:0]           csr_rdata_i, lsu_rdata_i, jump_target_o;
  alu_req_t                  alu_req_i;
  mult_req_t                 mult_req_i;
  wr_port_t                  alu_fw_o, wb_o;
  logic                      branch_decision_o, mult_multicycle_o, ex_ready_o, ex_valid_o;

  logic [31:0] rng_state = 32'h0552_54b8;
  int          cycle_count = 0;

  bind ex_stage ex_stage_properties u_props (.*);

  ex_stage u_ex_stage (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Checks failed");
      $fatal(1, "timeout, run did not finish within %0d cycles", max_cycles);
    end
  end

  // Stop at the first assertion failure
  initial begin
    wait (u_ex_stage.u_props.error_seen);
    $display("Checks failed");
    $fatal(1, "assertion failure in the execute stage");
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // LCG step
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // High with the given percentage
  function automatic logic chance(int unsigned pct);
    return ((next_rand() >> 8) % 100) < pct;
  endfunction

  task automatic clear_inputs();
    alu_en_i       <= 1'b0;
    mult_en_i      <= 1'b0;
    csr_access_i   <= 1'b0;
    lsu_en_i       <= 1'b0;
    regfile_we_i   <= 1'b0;
    branch_in_ex_i <= 1'b0;
    lsu_ready_ex_i <= 1'b1;
    wb_ready_i     <= 1'b1;
  endtask

  // Fresh operands, opcodes, data and addresses
  task automatic load_operands(input logic same_ab);
    logic [xlen-1:0] a;
    a = next_rand();
    alu_req_i.op        <= alu_op_e'((next_rand() >> 8) % 14);
    alu_req_i.a         <= a;
    alu_req_i.b         <= same_ab ? a : next_rand();
    alu_req_i.c         <= next_rand();
    mult_req_i.op       <= mult_op_e'(next_rand() >> 30);
    mult_req_i.a        <= next_rand();
    mult_req_i.b        <= next_rand();
    csr_rdata_i         <= next_rand();
    lsu_rdata_i         <= next_rand();
    regfile_alu_we_i    <= chance(70);
    regfile_alu_waddr_i <= reg_addr_width'(next_rand() >> 8);
    regfile_waddr_i     <= reg_addr_width'(next_rand() >> 16);
  endtask

  // Hold the instruction until the stage takes it
  task automatic wait_accept();
    @(negedge clk);
    while (!ex_ready_o) @(negedge clk);
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    rst_n <= 1'b0;
    clear_inputs();
    load_operands(1'b0);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // ALU ops and compares
    for (int i = 0; i < 40; i++) begin
      load_operands(i % 3 == 0);
      alu_en_i <= 1'b1;
      wait_accept();
    end

    // Branches finish while WB pushes back
    for (int i = 0; i < 6; i++) begin
      load_operands(i % 2 == 0);
      alu_req_i.op   <= alu_op_e'(8 + i);
      branch_in_ex_i <= 1'b1;
      wb_ready_i     <= 1'b0;
      wait_accept();
    end
    clear_inputs();

    // Each multiply op alone, then with the ALU also enabled
    // Second half of each group of eight stalls WB for three cycles
    for (int i = 0; i < 16; i++) begin
      load_operands(1'b0);
      mult_req_i.op <= mult_op_e'(i % 4);
      mult_en_i     <= 1'b1;
      alu_en_i      <= (i >= 8);
      if (i % 8 >= 4) begin
        wb_ready_i <= 1'b0;
        repeat (3) @(posedge clk);
        wb_ready_i <= 1'b1;
      end
      wait_accept();
    end

    // CSR data over both units
    for (int i = 0; i < 10; i++) begin
      load_operands(1'b0);
      csr_access_i <= 1'b1;
      alu_en_i     <= chance(50);
      mult_en_i    <= chance(50);
      wait_accept();
    end
    clear_inputs();

    // Load port and stall paths with a new word every cycle
    for (int i = 0; i < 60; i++) begin
      load_operands(1'b0);
      alu_en_i       <= chance(30);
      lsu_en_i       <= chance(50);
      regfile_we_i   <= chance(60);
      lsu_ready_ex_i <= chance(80);
      wb_ready_i     <= chance(80);
      branch_in_ex_i <= chance(20);
      @(posedge clk);
    end

    // Idle cycles with WB ready flush the load port
    clear_inputs();
    repeat (4) @(posedge clk);
    @(negedge clk);

    if (u_ex_stage.u_props.error_seen) begin
      $display("Checks failed");
      $fatal(1, "assertion failure in the execute stage");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- ex_stage_properties.sv
//////////////////////////////////////////////////
// Execute stage checker
// Reference model of the ALU, multiply, stall and
// write-back rules, compared on every clock
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage_properties import ex_pkg::*; (
  input logic                      clk, rst_n,
  input logic                      alu_en_i, mult_en_i, csr_access_i, lsu_en_i,
  input alu_req_t                  alu_req_i,
  input mult_req_t                 mult_req_i,
  input logic [xlen-1:0]           csr_rdata_i, lsu_rdata_i,
  input logic                      lsu_ready_ex_i, wb_ready_i, branch_in_ex_i,
  input logic                      regfile_alu_we_i, regfile_we_i,
  input logic [reg_addr_width-1:0] regfile_alu_waddr_i, regfile_waddr_i,
  input wr_port_t                  alu_fw_o, wb_o,
  input logic [xlen-1:0]           jump_target_o,
  input logic                      branch_decision_o, mult_multicycle_o,
  input logic                      ex_ready_o, ex_valid_o
);

  // Sticky flag raised by a failing check
  logic error_seen = 1'b0;

  // Model state
  logic                      busy_q;
  logic [xlen-1:0]           hi_q;
  logic                      exp_we_q;
  logic [reg_addr_width-1:0] exp_waddr_q;
  logic                      a_cycle, units_ready, exp_ready, exp_valid, exp_branch;
  wr_port_t                  fw_exp;

  //////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////

  // Branch compare, zero for non-compare ops
  function automatic logic cmp_ref(alu_op_e op, logic [xlen-1:0] a, logic [xlen-1:0] b);
    logic lt;
    // Differing signs decide a signed compare on their own
    lt = (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b);
    case (op)
      alu_eq:  return a == b;
      alu_ne:  return a != b;
      alu_lt:  return lt;
      alu_ltu: return a < b;
      alu_ge:  return !lt;
      alu_geu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [xlen-1:0] alu_ref(alu_op_e op, logic [xlen-1:0] a,
                                               logic [xlen-1:0] b);
    logic [4:0]      sh;
    logic [xlen-1:0] fill;
    sh   = b[4:0];
    // Sign copies shifted in from the top for sra
    fill = a[xlen-1] ? ~({xlen{1'b1}} >> sh) : '0;
    case (op)
      alu_add: return a + b;
      alu_sub: return a + ~b + 1'b1;
      alu_and: return a & b;
      alu_or:  return a | b;
      alu_xor: return a ^ b;
      alu_sll: return a << sh;
      alu_srl: return a >> sh;
      alu_sra: return (a >> sh) | fill;
      default: return {{(xlen-1){1'b0}}, cmp_ref(op, a, b)};
    endcase
  endfunction

  // Upper half from the unsigned product with sign corrections
  function automatic logic [xlen-1:0] hi_ref(mult_op_e op, logic [xlen-1:0] a,
                                              logic [xlen-1:0] b);
    logic [2*xlen-1:0] p;
    p = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};
    if (op != mult_mulhu && a[xlen-1]) p = p - {b, {xlen{1'b0}}};
    if (op == mult_mulh && b[xlen-1]) p = p - {a, {xlen{1'b0}}};
    return p[2*xlen-1:xlen];
  endfunction

  //////////////////////////////////////////////////
  // Expected behavior
  //////////////////////////////////////////////////

  // First cycle of a high-half multiply
  assign a_cycle     = mult_en_i && (mult_req_i.op != mult_mul) && !busy_q;
  assign units_ready = !a_cycle && lsu_ready_ex_i && wb_ready_i;
  assign exp_ready   = units_ready || branch_in_ex_i;
  assign exp_valid   = (alu_en_i || mult_en_i || csr_access_i || lsu_en_i) && units_ready;
  assign exp_branch  = alu_en_i && cmp_ref(alu_req_i.op, alu_req_i.a, alu_req_i.b);

  always_comb begin
    fw_exp.we    = regfile_alu_we_i;
    fw_exp.waddr = regfile_alu_waddr_i;
    fw_exp.wdata = '0;
    if (alu_en_i) fw_exp.wdata = alu_ref(alu_req_i.op, alu_req_i.a, alu_req_i.b);
    if (mult_en_i) fw_exp.wdata = busy_q ? hi_q : mult_req_i.a * mult_req_i.b;
    if (csr_access_i) fw_exp.wdata = csr_rdata_i;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      exp_we_q <= 1'b0;
    end else begin
      if (a_cycle) busy_q <= 1'b1;
      else if (exp_ready) busy_q <= 1'b0;
      if (exp_valid) exp_we_q <= regfile_we_i;
      else if (wb_ready_i) exp_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (a_cycle) hi_q <= hi_ref(mult_req_i.op, mult_req_i.a, mult_req_i.b);
    if (exp_valid && regfile_we_i) exp_waddr_q <= regfile_waddr_i;
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Data in cycle A is not defined unless the CSR owns the port
  fw_port_a: assert property (@(posedge clk) disable iff (!rst_n)
    !a_cycle || csr_access_i |-> alu_fw_o == fw_exp)
    else begin
      error_seen = 1'b1;
      $error("[ERROR] alu_fw_o got %h expected %h", $sampled(alu_fw_o), $sampled(fw_exp));
    end

  branch_a: assert property (@(posedge clk) disable iff (!rst_n)
    {branch_decision_o, jump_target_o} == {exp_branch, alu_req_i.c})
    else begin
      error_seen = 1'b1;
      $error("[ERROR] branch_decision_o/jump_target_o got %h expected %h",
             $sampled({branch_decision_o, jump_target_o}),
             $sampled({exp_branch, alu_req_i.c}));
    end

  stall_a: assert property (@(posedge clk) disable iff (!rst_n)
    {ex_ready_o, ex_valid_o} == {exp_ready, exp_valid})
    else begin
      error_seen = 1'b1;
      $error("[ERROR] ex_ready_o/ex_valid_o got %h expected %h",
             $sampled({ex_ready_o, ex_valid_o}), $sampled({exp_ready, exp_valid}));
    end

  multicycle_a: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_o == busy_q)
    else begin
      error_seen = 1'b1;
      $error("[ERROR] mult_multicycle_o got %h expected %h",
             $sampled(mult_multicycle_o), $sampled(busy_q));
    end

  wb_port_a: assert property (@(posedge clk) disable iff (!rst_n)
    wb_o.we == exp_we_q && (!exp_we_q || wb_o.waddr == exp_waddr_q)
    && wb_o.wdata == lsu_rdata_i)
    else begin
      error_seen = 1'b1;
      $error("[ERROR] wb_o got %h expected we %h waddr %h wdata %h", $sampled(wb_o),
             $sampled(exp_we_q), $sampled(exp_waddr_q), $sampled(lsu_rdata_i));
    end

endmodule

//--- ex_stage.sv
//////////////////////////////////////////////////
// Execute stage top level
// Hosts the ALU, multiplier and write-back block
// and drives the branch decision and jump target
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  // ALU request
  input  logic                      alu_en_i,
  input  alu_req_t                  alu_req_i,
  // Multiplier request
  input  logic                      mult_en_i,
  input  mult_req_t                 mult_req_i,
  // CSR read data
  input  logic                      csr_access_i,
  input  logic [xlen-1:0]           csr_rdata_i,
  // Load/store unit
  input  logic                      lsu_en_i,
  input  logic [xlen-1:0]           lsu_rdata_i,
  input  logic                      lsu_ready_ex_i,
  // Decode side
  input  logic                      branch_in_ex_i,
  input  logic                      regfile_alu_we_i,
  input  logic [reg_addr_width-1:0] regfile_alu_waddr_i,
  input  logic                      regfile_we_i,
  input  logic [reg_addr_width-1:0] regfile_waddr_i,
  input  logic                      wb_ready_i,
  // Write ports
  output wr_port_t                  alu_fw_o,
  output wr_port_t                  wb_o,
  // Towards fetch
  output logic [xlen-1:0]           jump_target_o,
  output logic                      branch_decision_o,
  // Status and handshake
  output logic                      mult_multicycle_o,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  logic [xlen-1:0] alu_result;
  logic            alu_cmp_result;
  logic [xlen-1:0] mult_result;
  logic            mult_ready;

  // Branch outcome straight from the compare
  assign branch_decision_o = alu_cmp_result;
  // Target is precomputed upstream on operand c
  assign jump_target_o     = alu_req_i.c;

  //////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////

  ex_alu u_alu (
    .enable_i     (alu_en_i),
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Stage ready closes the high-half sequence
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .req_i        (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////////////////////////
  // Write-back and pipeline control
  //////////////////////////////////////////////////

  ex_writeback u_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .alu_fw_o            (alu_fw_o),
    .wb_o                (wb_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

//--- ex_writeback.sv
//////////////////////////////////////////////////
// Execute write-back and pipeline control
// Forwarding port mux, EX/WB load-port register
// and the ex_ready / ex_valid stall logic
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_writeback import ex_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  // Unit enables
  input  logic                      alu_en_i,
  input  logic                      mult_en_i,
  input  logic                      csr_access_i,
  input  logic                      lsu_en_i,
  // Result sources
  input  logic [xlen-1:0]           alu_result_i,
  input  logic [xlen-1:0]           mult_result_i,
  input  logic [xlen-1:0]           csr_rdata_i,
  input  logic [xlen-1:0]           lsu_rdata_i,
  // Destinations from decode
  input  logic                      regfile_alu_we_i,
  input  logic [reg_addr_width-1:0] regfile_alu_waddr_i,
  input  logic                      regfile_we_i,
  input  logic [reg_addr_width-1:0] regfile_waddr_i,
  // Handshake
  input  logic                      mult_ready_i,
  input  logic                      lsu_ready_ex_i,
  input  logic                      wb_ready_i,
  input  logic                      branch_in_ex_i,
  output wr_port_t                  alu_fw_o,
  output wr_port_t                  wb_o,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  // EX/WB register for the load port
  logic                      wb_we_q;
  logic [reg_addr_width-1:0] wb_waddr_q;

  // All downstream parties can take a result
  logic units_ready;

  //////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////

  always_comb begin
    alu_fw_o.we    = regfile_alu_we_i;
    alu_fw_o.waddr = regfile_alu_waddr_i;
    alu_fw_o.wdata = '0;
    // Later source overrides the earlier one
    if (alu_en_i)     alu_fw_o.wdata = alu_result_i;
    if (mult_en_i)    alu_fw_o.wdata = mult_result_i;
    if (csr_access_i) alu_fw_o.wdata = csr_rdata_i;
  end

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      wb_we_q <= regfile_we_i;
    end else if (wb_ready_i) begin
      // Nothing new arrived, flush the old write out
      wb_we_q <= 1'b0;
    end
  end

  // Address only moves with an enabled write
  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i) begin
      wb_waddr_q <= regfile_waddr_i;
    end
  end

  // Load data arrives straight from the LSU
  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

  //////////////////////////////////////////////////
  // Stall logic
  //////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish here and never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid goes forward without looking at ex_ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

endmodule

//--- ex_mult.sv
//////////////////////////////////////////////////
// Integer multiplier
// Low-half multiply answers in the same cycle,
// high-half ops run a fixed two-cycle sequence
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_mult import ex_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            enable_i,
  input  mult_req_t       req_i,
  input  logic            ex_ready_i,
  output logic [xlen-1:0] result_o,
  output logic            ready_o,
  output logic            multicycle_o
);

  // Idle, or holding the registered upper half
  typedef enum logic {
    mult_idle,
    mult_high
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  // Operand signedness per opcode
  logic a_signed;
  logic b_signed;

  // One extra bit carries the sign or a zero
  logic signed [xlen:0] op_a_ext;
  logic signed [xlen:0] op_b_ext;

  // Product of the extended operands, low 2*xlen bits are exact
  logic signed [2*xlen+1:0] prod_full;
  logic        [2*xlen-1:0] product;

  // Registered upper half for the second step
  logic [xlen-1:0] prod_hi_q;

  logic high_op;
  logic start_high;

  //////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////

  assign a_signed = (req_i.op == mult_mulh) || (req_i.op == mult_mulhsu);
  assign b_signed = (req_i.op == mult_mulh);

  assign op_a_ext = $signed({a_signed & req_i.a[xlen-1], req_i.a});
  assign op_b_ext = $signed({b_signed & req_i.b[xlen-1], req_i.b});

  assign prod_full = op_a_ext * op_b_ext;
  assign product   = prod_full[2*xlen-1:0];

  // Any opcode other than mul needs the upper half
  assign high_op    = (req_i.op != mult_mul);
  assign start_high = enable_i && high_op && (state_q == mult_idle);

  //////////////////////////////////////////////////
  // High-half sequence
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Cycle A, product goes into the register
      mult_idle: if (start_high) state_d = mult_high;
      // Cycle B, held until the stage accepts it
      mult_high: if (ex_ready_i) state_d = mult_idle;
      default:   state_d = mult_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mult_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Captured in cycle A only, so back-pressure in B keeps it
  always_ff @(posedge clk) begin
    if (start_high) begin
      prod_hi_q <= product[2*xlen-1:xlen];
    end
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Not ready only during cycle A
  assign ready_o      = ~start_high;
  assign multicycle_o = (state_q == mult_high);

  always_comb begin
    if (state_q == mult_high) begin
      result_o = prod_hi_q;
    end else if (enable_i && !high_op) begin
      result_o = product[xlen-1:0];
    end else begin
      result_o = '0;
    end
  end

endmodule

//--- ex_alu.sv
//////////////////////////////////////////////////
// Integer ALU
// Add, subtract, logic, shifts and compares
// Purely combinational, compare bit feeds branches
//////////////////////////////////////////////////

`timescale 1ns/1ps

module ex_alu import ex_pkg::*; (
  input  logic            enable_i,
  input  alu_req_t        req_i,
  output logic [xlen-1:0] result_o,
  output logic            cmp_result_o
);

  // Shift amount
  logic [shamt_width-1:0] shamt;

  // Arithmetic and shift results
  logic [xlen-1:0] sum;
  logic [xlen-1:0] diff;
  logic [xlen-1:0] shift_left;
  logic [xlen-1:0] shift_right_log;
  logic [xlen-1:0] shift_right_arith;

  // Compare flags
  logic is_equal;
  logic less_signed;
  logic less_unsigned;

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  assign shamt = req_i.b[shamt_width-1:0];

  assign sum  = req_i.a + req_i.b;
  assign diff = req_i.a - req_i.b;

  // Barrel shifts
  assign shift_left        = req_i.a << shamt;
  assign shift_right_log   = req_i.a >> shamt;
  assign shift_right_arith = $unsigned($signed(req_i.a) >>> shamt);

  // Compare flags shared by the six compare ops
  assign is_equal      = (req_i.a == req_i.b);
  assign less_signed   = ($signed(req_i.a) < $signed(req_i.b));
  assign less_unsigned = (req_i.a < req_i.b);

  //////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////

  always_comb begin
    result_o     = '0;
    cmp_result_o = 1'b0;

    // Everything stays zero while disabled
    if (enable_i) begin
      case (req_i.op)
        alu_add: result_o = sum;
        alu_sub: result_o = diff;
        alu_and: result_o = req_i.a & req_i.b;
        alu_or:  result_o = req_i.a | req_i.b;
        alu_xor: result_o = req_i.a ^ req_i.b;
        alu_sll: result_o = shift_left;
        alu_srl: result_o = shift_right_log;
        alu_sra: result_o = shift_right_arith;

        // Compares drive the branch bit
        alu_eq:  cmp_result_o = is_equal;
        alu_ne:  cmp_result_o = ~is_equal;
        alu_lt:  cmp_result_o = less_signed;
        alu_ltu: cmp_result_o = less_unsigned;
        alu_ge:  cmp_result_o = ~less_signed;
        alu_geu: cmp_result_o = ~less_unsigned;

        default: begin
          result_o     = '0;
          cmp_result_o = 1'b0;
        end
      endcase

      // Compare result also shows up as a zero-extended word
      if (req_i.op inside {alu_eq, alu_ne, alu_lt, alu_ltu, alu_ge, alu_geu}) begin
        result_o = {{(xlen-1){1'b0}}, cmp_result_o};
      end
    end
  end

endmodule

//--- ex_pkg.sv
//////////////////////////////////////////////////
// Execute stage shared definitions
// Width constants, ALU and multiplier opcodes,
// request bundles and register-file write ports
//////////////////////////////////////////////////

package ex_pkg;

  // Integer datapath width
  localparam int unsigned xlen = 32;

  // Register address width, room for the extended register space
  localparam int unsigned reg_addr_width = 6;

  // Shift amount taken from the low bits of operand b
  localparam int unsigned shamt_width = 5;

  //////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////

  // ALU operations
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    // Compares, also used for branches
    alu_eq   = 4'd8,
    alu_ne   = 4'd9,
    alu_lt   = 4'd10,
    alu_ltu  = 4'd11,
    alu_ge   = 4'd12,
    alu_geu  = 4'd13
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [1:0] {
    mult_mul    = 2'd0,
    mult_mulh   = 2'd1,
    mult_mulhu  = 2'd2,
    mult_mulhsu = 2'd3
  } mult_op_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // ALU request, operand c carries the jump target
  typedef struct packed {
    alu_op_e         op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] c;
  } alu_req_t;

  // Multiplier request
  typedef struct packed {
    mult_op_e        op;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
  } mult_req_t;

  // Register-file write port
  typedef struct packed {
    logic                      we;
    logic [reg_addr_width-1:0] waddr;
    logic [xlen-1:0]           wdata;
  } wr_port_t;

endpackage
